/* hdl/uma_settings.svh */
`ifndef UMA_SETTINGS_SVH
`define UMA_SETTINGS_SVH

// Shared sizes for the cartridge memory-sharing core

// Word address width of the shared RAM
// 16K words of 32 bits cover the full 64 KB host space
`define UMA_WORD_ADDR_WIDTH 14

// First word of the video region
// Host byte address 0x8000 maps here
`define UMA_VRAM_BASE 'h2000

// Words read by the fetcher on each line
`define UMA_LINE_WORDS 8

// Lines per frame, line index wraps after this
`define UMA_LINE_COUNT 16

`endif

/* hdl/ram_pkg.sv */
`include "uma_settings.svh"

// Memory side types
package ram_pkg;

    // Byte lanes per RAM word
    localparam int LANE_COUNT = 4;

    // One RAM word
    typedef logic [31:0] word_t;

    // RAM word address
    typedef logic [`UMA_WORD_ADDR_WIDTH-1:0] word_addr_t;

    // Byte write enables, bit n writes byte n
    typedef logic [LANE_COUNT-1:0] lane_mask_t;

    // Same word seen two ways
    // Whole word for the RAM path, per-lane bytes for the host side
    // Lane 0 is the low byte (little endian)
    typedef union packed {
        word_t                          word;
        logic [LANE_COUNT-1:0][7:0]     lane;
    } ram_word_u;

endpackage

/* hdl/bus_pkg.sv */
// Client side types
package bus_pkg;

    // Host byte address on the cartridge slot
    typedef logic [15:0] cart_addr_t;

    // Host data byte
    typedef logic [7:0] cart_byte_t;

    // Arbiter client index
    typedef logic client_t;

    // Client numbering
    localparam client_t CLIENT_CART  = 1'b0;
    localparam client_t CLIENT_VIDEO = 1'b1;

endpackage

/* hdl/ram_block.sv */
`timescale 1ns/100ps

// Shared on-chip RAM
// Single port, byte-lane writes, registered read
module ram_block (
    input  logic                CLK,
    input  logic                ram_en,
    input  logic                ram_we,
    input  ram_pkg::word_addr_t ram_addr,
    input  ram_pkg::word_t      ram_wdata,
    input  ram_pkg::lane_mask_t ram_lanes,
    output ram_pkg::word_t      ram_rdata
);
    import ram_pkg::*;

    // Whole address space of word_addr_t
    localparam int DEPTH = 2 ** $bits(word_addr_t);

    // Contents start undefined
    ram_word_u mem [0:DEPTH-1];

    always_ff @(posedge CLK) begin
        if (ram_en) begin
            // Only the enabled lanes change
            for (int n = 0; n < LANE_COUNT; n++) begin
                if (ram_we && ram_lanes[n]) begin
                    mem[ram_addr].word[n*8 +: 8] <= ram_wdata[n*8 +: 8];
                end
            end
            // Old data on a write cycle
            ram_rdata <= mem[ram_addr].word;
        end
    end

endmodule

/* hdl/uma_arbiter.sv */
`timescale 1ns/100ps

// Two-client round-robin arbiter in front of the shared RAM
// Grant cycle drives the RAM, next cycle carries data and ack
module uma_arbiter (
    input  logic                CLK,
    input  logic                CLK_BASE_READY,

    // Cartridge client
    input  logic                cart_req,
    input  logic                cart_we,
    input  ram_pkg::word_addr_t cart_addr_w,
    input  ram_pkg::word_t      cart_wdata,
    input  ram_pkg::lane_mask_t cart_lanes,
    output logic                cart_ack,

    // Video client, reads only
    input  logic                video_req,
    input  ram_pkg::word_addr_t video_addr,
    output logic                video_ack,

    // Read data for whichever client is acked
    output ram_pkg::word_t      rdata,

    // RAM side
    output logic                ram_en,
    output logic                ram_we,
    output ram_pkg::word_addr_t ram_addr,
    output ram_pkg::word_t      ram_wdata,
    output ram_pkg::lane_mask_t ram_lanes,
    input  ram_pkg::word_t      ram_rdata
);
    import bus_pkg::*;

    // Access in flight, RAM data due this cycle
    logic    busy_q;
    // Client owning the access in flight
    client_t grant_q;
    // Client of the last finished access
    logic    last_q;
    // Client picked in this cycle
    client_t sel;

    // Tie goes to whoever was not served last
    always_comb begin
        if (cart_req && video_req) begin
            sel = ~last_q;
        end else if (video_req) begin
            sel = CLIENT_VIDEO;
        end else begin
            sel = CLIENT_CART;
        end
    end

    // Grant only from idle
    assign ram_en    = ~busy_q & (cart_req | video_req);
    assign ram_we    = ram_en & (sel == CLIENT_CART) & cart_we;
    assign ram_addr  = (sel == CLIENT_VIDEO) ? video_addr : cart_addr_w;
    // Write payload only ever comes from the cartridge side
    assign ram_wdata = cart_wdata;
    assign ram_lanes = cart_lanes;

    always_ff @(posedge CLK or negedge CLK_BASE_READY) begin
        if (!CLK_BASE_READY) begin
            busy_q  <= 1'b0;
            grant_q <= CLIENT_CART;
            // Cartridge wins the first tie
            last_q  <= CLIENT_VIDEO;
        end else if (busy_q) begin
            // Ack cycle, idle again next
            busy_q <= 1'b0;
            last_q <= grant_q;
        end else if (ram_en) begin
            busy_q  <= 1'b1;
            grant_q <= sel;
        end
    end

    // One-cycle ack pulses, data straight from the RAM register
    assign cart_ack  = busy_q & (grant_q == CLIENT_CART);
    assign video_ack = busy_q & (grant_q == CLIENT_VIDEO);
    assign rdata     = ram_rdata;

endmodule

/* hdl/cart_port.sv */
`timescale 1ns/100ps

// Cartridge slot slave
// One host cycle becomes one byte access to the shared RAM
module cart_port (
    input  logic                CLK,
    input  logic                CLK_BASE_READY,

    // Host pins
    input  logic                cart_sltsl_n,
    input  logic                cart_rd_n,
    input  logic                cart_wr_n,
    input  bus_pkg::cart_addr_t cart_addr,
    input  bus_pkg::cart_byte_t cart_data_in,
    output bus_pkg::cart_byte_t cart_data_out,
    output logic                cart_data_oe,
    output logic                cart_wait_n,

    // Arbiter client
    output logic                cart_req,
    output logic                cart_we,
    output ram_pkg::word_addr_t cart_addr_w,
    output ram_pkg::word_t      cart_wdata,
    output ram_pkg::lane_mask_t cart_lanes,
    input  logic                cart_ack,
    input  ram_pkg::word_t      rdata
);
    import ram_pkg::*;
    import bus_pkg::*;

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_ACCESS = 2'd1;
    localparam logic [1:0] ST_HOLD   = 2'd2;

    logic [1:0] state_q;

    // Two-flop synchronizers, bit 1 is safe to use
    logic [1:0] sltsl_sync_q;
    logic [1:0] rd_sync_q;
    logic [1:0] wr_sync_q;
    logic       host_start;
    logic       host_released;

    // Access captured at cycle start
    cart_addr_t addr_q;
    cart_byte_t wbyte_q;
    ram_word_u  wdata_u;
    ram_word_u  rdata_u;

    always_ff @(posedge CLK or negedge CLK_BASE_READY) begin
        if (!CLK_BASE_READY) begin
            sltsl_sync_q <= 2'b11;
            rd_sync_q    <= 2'b11;
            wr_sync_q    <= 2'b11;
        end else begin
            sltsl_sync_q <= {sltsl_sync_q[0], cart_sltsl_n};
            rd_sync_q    <= {rd_sync_q[0], cart_rd_n};
            wr_sync_q    <= {wr_sync_q[0], cart_wr_n};
        end
    end

    // Slot selected with a read or write strobe
    assign host_start    = ~sltsl_sync_q[1] & (~rd_sync_q[1] | ~wr_sync_q[1]);
    // Host has ended its cycle
    assign host_released = sltsl_sync_q[1] | (rd_sync_q[1] & wr_sync_q[1]);

    always_ff @(posedge CLK or negedge CLK_BASE_READY) begin
        if (!CLK_BASE_READY) begin
            state_q      <= ST_IDLE;
            cart_req     <= 1'b0;
            cart_we      <= 1'b0;
            cart_wait_n  <= 1'b1;
            cart_data_oe <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: if (host_start) begin
                    state_q     <= ST_ACCESS;
                    cart_req    <= 1'b1;
                    cart_we     <= ~wr_sync_q[1];
                    // Stall the host until the RAM answers
                    cart_wait_n <= 1'b0;
                end
                ST_ACCESS: if (cart_ack) begin
                    state_q      <= ST_HOLD;
                    cart_req     <= 1'b0;
                    cart_wait_n  <= 1'b1;
                    cart_data_oe <= ~cart_we;
                end
                // Wait for the strobes to rise so one host cycle is one access
                ST_HOLD: if (host_released) begin
                    state_q      <= ST_IDLE;
                    cart_data_oe <= 1'b0;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state_q == ST_IDLE && host_start) begin
            addr_q  <= cart_addr;
            wbyte_q <= cart_data_in;
        end
        // Read byte held for the rest of the host cycle
        if (state_q == ST_ACCESS && cart_ack && !cart_we) begin
            cart_data_out <= rdata_u.lane[addr_q[1:0]];
        end
    end

    always_comb begin
        // Byte in every lane, the mask picks the one that lands
        wdata_u.lane = {LANE_COUNT{wbyte_q}};
        rdata_u.word = rdata;
    end

    // Byte address 15:2 is the word address
    assign cart_addr_w = addr_q[15:2];
    assign cart_wdata  = wdata_u.word;
    assign cart_lanes  = lane_mask_t'(1) << addr_q[1:0];

endmodule

/* hdl/video_fetch.sv */
`timescale 1ns/100ps

`include "uma_settings.svh"

// Video line fetcher
// Reads one line of words per line_start and streams them out
module video_fetch (
    input  logic                CLK,
    input  logic                CLK_BASE_READY,
    input  logic                frame_start,
    input  logic                line_start,

    // Arbiter client
    output logic                video_req,
    output ram_pkg::word_addr_t video_addr,
    input  logic                video_ack,
    input  ram_pkg::word_t      rdata,

    // Pixel stream
    output ram_pkg::word_t      pixel_word,
    output logic                pixel_valid,
    output logic                line_done
);
    import ram_pkg::*;

    // Extra bit so a full line count fits
    localparam int CNT_W = $clog2(`UMA_LINE_WORDS) + 1;
    localparam int IDX_W = $clog2(`UMA_LINE_COUNT);

    logic             active_q;
    logic [CNT_W-1:0] word_cnt_q;
    logic [IDX_W-1:0] line_idx_q;
    // First word of the current line
    word_addr_t       line_base_q;
    logic             line_end;

    assign line_end   = (word_cnt_q == CNT_W'(`UMA_LINE_WORDS));
    assign video_addr = line_base_q + word_addr_t'(word_cnt_q);

    always_ff @(posedge CLK or negedge CLK_BASE_READY) begin
        if (!CLK_BASE_READY) begin
            active_q    <= 1'b0;
            video_req   <= 1'b0;
            word_cnt_q  <= '0;
            line_idx_q  <= '0;
            pixel_valid <= 1'b0;
            line_done   <= 1'b0;
        end else begin
            pixel_valid <= 1'b0;
            line_done   <= 1'b0;
            if (!active_q) begin
                // line_start while busy is dropped
                if (line_start) begin
                    active_q   <= 1'b1;
                    video_req  <= 1'b1;
                    word_cnt_q <= '0;
                end
            end else if (video_req) begin
                if (video_ack) begin
                    video_req   <= 1'b0;
                    pixel_valid <= 1'b1;
                    word_cnt_q  <= word_cnt_q + 1'b1;
                end
            end else if (line_end) begin
                active_q  <= 1'b0;
                line_done <= 1'b1;
                if (line_idx_q == IDX_W'(`UMA_LINE_COUNT - 1)) begin
                    line_idx_q <= '0;
                end else begin
                    line_idx_q <= line_idx_q + 1'b1;
                end
            end else begin
                // Gap cycle after each ack, then the next word
                video_req <= 1'b1;
            end
            // Frame restart wins over line advance
            if (frame_start) begin
                line_idx_q <= '0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!active_q && line_start) begin
            line_base_q <= word_addr_t'(`UMA_VRAM_BASE + line_idx_q * `UMA_LINE_WORDS);
        end
        if (video_req && video_ack) begin
            pixel_word <= rdata;
        end
    end

endmodule

/* hdl/cart_uma_top.sv */
`timescale 1ns/100ps

// Cartridge port and video fetcher sharing one RAM
module cart_uma_top (
    input  logic                CLK,
    input  logic                CLK_BASE_READY,

    // Cartridge slot
    input  logic                cart_sltsl_n,
    input  logic                cart_rd_n,
    input  logic                cart_wr_n,
    input  bus_pkg::cart_addr_t cart_addr,
    input  bus_pkg::cart_byte_t cart_data_in,
    output bus_pkg::cart_byte_t cart_data_out,
    output logic                cart_data_oe,
    output logic                cart_wait_n,

    // Video timing and pixel stream
    input  logic                frame_start,
    input  logic                line_start,
    output ram_pkg::word_t      pixel_word,
    output logic                pixel_valid,
    output logic                line_done
);
    import ram_pkg::*;

    // Cartridge client
    logic       cart_req;
    logic       cart_we;
    word_addr_t cart_addr_w;
    word_t      cart_wdata;
    lane_mask_t cart_lanes;
    logic       cart_ack;

    // Video client
    logic       video_req;
    word_addr_t video_addr;
    logic       video_ack;

    // Shared read data
    word_t      rdata;

    // RAM port
    logic       ram_en;
    logic       ram_we;
    word_addr_t ram_addr;
    word_t      ram_wdata;
    lane_mask_t ram_lanes;
    word_t      ram_rdata;

    cart_port u_cart (
        .CLK, .CLK_BASE_READY,
        .cart_sltsl_n, .cart_rd_n, .cart_wr_n,
        .cart_addr, .cart_data_in, .cart_data_out,
        .cart_data_oe, .cart_wait_n,
        .cart_req, .cart_we, .cart_addr_w, .cart_wdata, .cart_lanes,
        .cart_ack, .rdata
    );

    video_fetch u_video (
        .CLK, .CLK_BASE_READY,
        .frame_start, .line_start,
        .video_req, .video_addr, .video_ack, .rdata,
        .pixel_word, .pixel_valid, .line_done
    );

    uma_arbiter u_arb (
        .CLK, .CLK_BASE_READY,
        .cart_req, .cart_we, .cart_addr_w, .cart_wdata, .cart_lanes, .cart_ack,
        .video_req, .video_addr, .video_ack,
        .rdata,
        .ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_lanes, .ram_rdata
    );

    ram_block u_ram (
        .CLK,
        .ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_lanes, .ram_rdata
    );

endmodule

/* verification/cart_uma_sva.sv */
`timescale 1ns/100ps

// Protocol checks on the shared memory core
module cart_uma_sva (
    input logic CLK,
    input logic CLK_BASE_READY,
    input logic cart_sltsl_n,
    input logic cart_ack,
    input logic video_ack,
    input logic cart_wait_n,
    input logic pixel_valid
);

    // One client served per access
    a_single_ack: assert property (
        @(posedge CLK) disable iff (!CLK_BASE_READY)
        !(cart_ack && video_ack)
    ) else $error("cart_ack and video_ack high in the same cycle");

    // Host never stalled while the slot is deselected
    a_wait_idle: assert property (
        @(posedge CLK) disable iff (!CLK_BASE_READY)
        cart_sltsl_n |-> cart_wait_n
    ) else $error("cart_wait_n low while the slot is not selected");

    // Each pixel follows a video ack by one cycle
    a_pixel_after_ack: assert property (
        @(posedge CLK) disable iff (!CLK_BASE_READY)
        pixel_valid |-> $past(video_ack)
    ) else $error("pixel_valid without a video_ack one cycle before");

endmodule

// Bound into the top level for its internal ack wires
bind cart_uma_top cart_uma_sva u_sva (
    .CLK, .CLK_BASE_READY, .cart_sltsl_n, .cart_ack, .video_ack, .cart_wait_n, .pixel_valid
);

/* verification/cart_uma_tb.sv */
`timescale 1ns/100ps

`include "uma_settings.svh"

// Directed tests for the cartridge port and video fetcher sharing one RAM
module cart_uma_tb;
    import ram_pkg::*;
    import bus_pkg::*;

    logic       CLK;
    logic       CLK_BASE_READY;
    logic       cart_sltsl_n;
    logic       cart_rd_n;
    logic       cart_wr_n;
    cart_addr_t cart_addr;
    cart_byte_t cart_data_in;
    cart_byte_t cart_data_out;
    logic       cart_data_oe;
    logic       cart_wait_n;
    logic       frame_start;
    logic       line_start;
    word_t      pixel_word;
    logic       pixel_valid;
    logic       line_done;

    // Host view of memory, mirrors every write
    cart_byte_t ref_mem [0:65535];
    // Low-region addresses written so far
    cart_addr_t low_addrs [$];
    // Pixel stream as seen by the monitor
    word_t      pix_q [$];
    int         done_cnt = 0;
    // Line the fetcher should read next
    int         exp_line = 0;
    int         errors = 0;
    int         checks = 0;
    int         tests_run = 0;
    int         tests_failed = 0;

    cart_uma_top u_dut (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // Sampled mid-cycle, away from the clock edge
    always @(negedge CLK) begin
        if (pixel_valid) begin
            pix_q.push_back(pixel_word);
        end
        if (line_done) begin
            done_cnt++;
        end
    end

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s", what);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_byte(input string name, input cart_byte_t expected,
                              input cart_byte_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: expected %02h, actual %02h", name, expected, actual);
        end
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    // Pulse and pixel counts
    task automatic check_count(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic wait_for_wait_n(input logic level, input string what);
        int n;
        n = 0;
        while (cart_wait_n !== level) begin
            if (n == 64) begin
                stop_on_timeout(what);
            end
            next_cycle();
            n++;
        end
    endtask

    // One host bus cycle, strobes held until wait releases
    task automatic host_cycle(input cart_addr_t addr, input logic write,
                              input cart_byte_t wdata, output cart_byte_t rbyte);
        cart_addr    = addr;
        cart_data_in = wdata;
        cart_sltsl_n = 1'b0;
        cart_rd_n    = write;
        cart_wr_n    = ~write;
        next_cycle();
        wait_for_wait_n(1'b0, "cart_wait_n never went low for a host cycle");
        wait_for_wait_n(1'b1, "cart_wait_n never returned high after an access");
        rbyte = cart_data_out;
        if (!write) begin
            check_bit("read data enable", 1'b1, cart_data_oe);
        end
        cart_sltsl_n = 1'b1;
        cart_rd_n    = 1'b1;
        cart_wr_n    = 1'b1;
        // Strobes must rise through the synchronizer before the next cycle
        repeat (4) next_cycle();
        check_bit("data enable after cycle", 1'b0, cart_data_oe);
    endtask

    task automatic host_write(input cart_addr_t addr, input cart_byte_t data);
        cart_byte_t unused;
        host_cycle(addr, 1'b1, data, unused);
        ref_mem[addr] = data;
    endtask

    task automatic host_read(input string name, input cart_addr_t addr);
        cart_byte_t got;
        host_cycle(addr, 1'b0, 8'h00, got);
        check_byte(name, ref_mem[addr], got);
    endtask

    // Little-endian word from the host bytes of one video line
    function automatic word_t expected_pixel(input int line, input int w);
        cart_addr_t base;
        base = cart_addr_t'((`UMA_VRAM_BASE + line * `UMA_LINE_WORDS + w) * 4);
        return {ref_mem[base + 16'd3], ref_mem[base + 16'd2],
                ref_mem[base + 16'd1], ref_mem[base]};
    endfunction

    task automatic restart_frame();
        frame_start = 1'b1;
        next_cycle();
        frame_start = 1'b0;
        exp_line = 0;
    endtask

    // Start a line, optionally pulse line_start again mid-line
    task automatic fetch_line(input string name, input logic extra_start);
        int start_done;
        int n;
        pix_q.delete();
        start_done = done_cnt;
        line_start = 1'b1;
        next_cycle();
        line_start = 1'b0;
        if (extra_start) begin
            repeat (3) next_cycle();
            line_start = 1'b1;
            next_cycle();
            line_start = 1'b0;
        end
        n = 0;
        while (done_cnt == start_done) begin
            if (n == 200) begin
                stop_on_timeout("line_done never pulsed after line_start");
            end
            next_cycle();
            n++;
        end
        // Room for a wrongly started second line to show
        repeat (40) next_cycle();
        check_count({name, " pixel count"}, `UMA_LINE_WORDS, pix_q.size());
        check_count({name, " line_done count"}, 1, done_cnt - start_done);
        for (int w = 0; w < pix_q.size(); w++) begin
            check_word(name, expected_pixel(exp_line, w), pix_q[w]);
        end
        exp_line = (exp_line + 1) % `UMA_LINE_COUNT;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_reset_state();
        int e0;
        e0 = errors;
        check_bit("reset cart_wait_n", 1'b1, cart_wait_n);
        check_bit("reset cart_data_oe", 1'b0, cart_data_oe);
        check_bit("reset pixel_valid", 1'b0, pixel_valid);
        check_bit("reset line_done", 1'b0, line_done);
        finish_test("reset_state", e0);
    endtask

    task automatic test_byte_access();
        int e0;
        cart_addr_t a;
        e0 = errors;
        // Scattered bytes below the video region
        for (int i = 0; i < 12; i++) begin
            a = cart_addr_t'($urandom() & 32'h7fff);
            host_write(a, cart_byte_t'($urandom()));
            low_addrs.push_back(a);
        end
        // All four lanes of one word, neighbours must survive
        a = cart_addr_t'($urandom() & 32'h7ffc);
        for (int n = 0; n < 4; n++) begin
            host_write(cart_addr_t'(a + n), cart_byte_t'($urandom()));
            low_addrs.push_back(cart_addr_t'(a + n));
        end
        foreach (low_addrs[i]) begin
            host_read("byte_access", low_addrs[i]);
        end
        finish_test("byte_access", e0);
    endtask

    task automatic test_video_line();
        int e0;
        e0 = errors;
        // Whole frame of video words, so later lines are known too
        for (int i = 0; i < `UMA_LINE_COUNT * `UMA_LINE_WORDS * 4; i++) begin
            host_write(cart_addr_t'(`UMA_VRAM_BASE * 4 + i), cart_byte_t'($urandom()));
        end
        restart_frame();
        fetch_line("video_line", 1'b0);
        finish_test("video_line", e0);
    endtask

    task automatic test_line_wrap();
        int e0;
        e0 = errors;
        // Remaining lines, then wrap to line 0 and on to line 1
        for (int i = 0; i <= `UMA_LINE_COUNT; i++) begin
            fetch_line("line_wrap", 1'b0);
        end
        restart_frame();
        fetch_line("frame_restart", 1'b0);
        finish_test("line_wrap", e0);
    endtask

    task automatic test_shared_access();
        int e0;
        e0 = errors;
        // Host reads contend with the line fetch
        fork
            fetch_line("shared_access", 1'b0);
            begin
                repeat (4) next_cycle();
                host_read("shared_access", low_addrs[0]);
                host_read("shared_access", low_addrs[1]);
            end
        join
        finish_test("shared_access", e0);
    endtask

    task automatic test_ignored_start();
        int e0;
        e0 = errors;
        fetch_line("ignored_start", 1'b1);
        finish_test("ignored_start", e0);
    endtask

    initial begin
        void'($urandom(54375));
        CLK_BASE_READY = 1'b0;
        cart_sltsl_n   = 1'b1;
        cart_rd_n      = 1'b1;
        cart_wr_n      = 1'b1;
        cart_addr      = '0;
        cart_data_in   = '0;
        frame_start    = 1'b0;
        line_start     = 1'b0;
        repeat (3) @(posedge CLK);
        #1;
        CLK_BASE_READY = 1'b1;
        next_cycle();

        test_reset_state();
        test_byte_access();
        test_video_line();
        test_line_wrap();
        test_shared_access();
        test_ignored_start();

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+hdl
hdl/ram_pkg.sv
hdl/bus_pkg.sv
hdl/ram_block.sv
hdl/uma_arbiter.sv
hdl/cart_port.sv
hdl/video_fetch.sv
hdl/cart_uma_top.sv
verification/cart_uma_sva.sv
verification/cart_uma_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the cartridge memory-sharing testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f files.f --top-module cart_uma_tb -o cart_uma_sim \
    || { echo "Verilator build failed"; exit 1; }

output="$(./obj_dir/cart_uma_sim 2>&1)"
echo "$output"

grep -q "TESTBENCH PASSED" <<< "$output" && exit 0 || exit 1
